/* Bender.yml */
package:
  name: cus47

sources:
  - design/sys86_bus_pkg.sv
  - design/sys86_timing_pkg.sv
  - design/cus47_phase_gen.sv
  - design/cus47_addr_decode.sv
  - design/cus47_vblank_watchdog.sv
  - design/cus47.sv
  - target: test
    files:
      - testbench/tb_cus47.sv

/* compile.f */
design/sys86_bus_pkg.sv
design/sys86_timing_pkg.sv
design/cus47_phase_gen.sv
design/cus47_addr_decode.sv
design/cus47_vblank_watchdog.sv
design/cus47.sv
testbench/tb_cus47.sv

/* design/cus47.sv */
`timescale 1ns/1ps
`default_nettype none

module cus47 #(
	// 4 bits gives a reset after 8 missed blanks
	parameter int watchdog_width = 4
) (
	input  logic                         clk_6m,
	input  logic                         reset,
	input  logic                         clk_2h,
	input  logic                         vblk,
	input  logic                         we,
	input  sys86_bus_pkg::addr_page_u    a,
	output sys86_timing_pkg::bus_phase_t phase,
	output sys86_bus_pkg::cpu_select_t   sel,
	output logic                         irq,
	output logic                         wdog_reset
);

	// decoder write strobes into the vblank block
	sys86_timing_pkg::ctrl_strobe_t strobe;

	////////////////////////////////////////
	// bus phases
	////////////////////////////////////////

	// watchdog reset also stops the phase chain
	cus47_phase_gen phase_gen_i (
		.clk_6m (clk_6m),
		.reset  (reset),
		.clear  (wdog_reset),
		.clk_2h (clk_2h),
		.phase  (phase)
	);

	////////////////////////////////////////
	// sub cpu address decode
	////////////////////////////////////////

	cus47_addr_decode addr_decode_i (
		.we     (we),
		.a      (a),
		.sel    (sel),
		.strobe (strobe)
	);

	////////////////////////////////////////
	// vblank interrupt and watchdog
	////////////////////////////////////////

	cus47_vblank_watchdog #(
		.watchdog_width (watchdog_width)
	) vblank_watchdog_i (
		.clk_6m     (clk_6m),
		.reset      (reset),
		.vblk       (vblk),
		.strobe     (strobe),
		.irq        (irq),
		.wdog_reset (wdog_reset)
	);

endmodule

`default_nettype wire

/* design/cus47_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cus47_addr_decode (
	input  logic                           we,
	input  sys86_bus_pkg::addr_page_u      a,
	output sys86_bus_pkg::cpu_select_t     sel,
	output sys86_timing_pkg::ctrl_strobe_t strobe
);

	////////////////////////////////////////
	// region compares at 8 KB granularity
	////////////////////////////////////////

	logic in_scr0;
	logic in_scr1;
	logic in_obj;
	logic in_spgm;

	assign in_scr0 = (a.split.region == sys86_bus_pkg::region_scr0);
	assign in_scr1 = (a.split.region == sys86_bus_pkg::region_scr1);
	assign in_obj  = (a.split.region == sys86_bus_pkg::region_obj);
	assign in_spgm = (a.split.region == sys86_bus_pkg::region_spgm);

	////////////////////////////////////////
	// page compares at 1 KB granularity
	////////////////////////////////////////

	logic pg_snd;
	logic pg_wdog;
	logic pg_ack;
	logic pg_bank;
	logic pg_lth0;
	logic pg_lth1;
	logic pg_lth2;

	assign pg_snd  = (a.page == sys86_bus_pkg::page_snd);
	assign pg_wdog = (a.page == sys86_bus_pkg::page_wdog);
	assign pg_ack  = (a.page == sys86_bus_pkg::page_irq_ack);
	assign pg_bank = (a.page == sys86_bus_pkg::page_bank);
	assign pg_lth0 = (a.page == sys86_bus_pkg::page_lth0);
	assign pg_lth1 = (a.page == sys86_bus_pkg::page_lth1);
	assign pg_lth2 = (a.page == sys86_bus_pkg::page_lth2);

	////////////////////////////////////////
	// select outputs
	////////////////////////////////////////

	always_comb begin
		// rams and sound chip decode on any access
		sel.scr0  = in_scr0;
		sel.scr1  = in_scr1;
		sel.obj   = in_obj;
		sel.snd   = pg_snd;
		// program roms are read only
		sel.spgm  = ~we & in_spgm;
		// main program rom covers 8000h up on a15 alone
		sel.mpgm  = ~we & a.split.region[2];
		// latches are write only
		sel.bank  = we & pg_bank;
		sel.lth0  = we & pg_lth0;
		sel.lth1  = we & pg_lth1;
		sel.lth2  = we & pg_lth2;
		// data buffer toward the shared bus
		// lth2 sits on the other side and is left out
		sel.bufen = in_scr0 | in_scr1 | in_obj | pg_snd | sel.lth0 | sel.lth1;
	end

	// write strobes for the vblank block
	assign strobe = '{
		irq_ack:   we & pg_ack,
		wdog_kick: we & pg_wdog
	};

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// rams and roms sit in disjoint regions of the memory map
	always_comb begin
		a_mem_onehot: assert ($onehot0({sel.scr0, sel.scr1, sel.obj, sel.spgm, sel.mpgm}))
			else $error("more than one memory select active");
	end

endmodule

`default_nettype wire

/* design/cus47_phase_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module cus47_phase_gen (
	input  logic                          clk_6m,
	input  logic                          reset,
	input  logic                          clear,
	input  logic                          clk_2h,
	output sys86_timing_pkg::bus_phase_t  phase
);

	////////////////////////////////////////
	// two stage shift of the 2h level
	////////////////////////////////////////

	// ckb is 2h delayed by one 6m edge
	logic ckb;
	// ckc is 2h delayed by two edges
	logic ckc;

	// board reset or watchdog reset both clear the chain
	always_ff @(posedge clk_6m) begin
		if (reset || clear) begin
			ckb <= 1'b0;
			ckc <= 1'b0;
		end else begin
			ckb <= clk_2h;
			ckc <= ckb;
		end
	end

	// main cpu takes the true outputs
	// sub cpu takes the inverted outputs
	assign phase = '{
		mq:   ckb,
		me:   ckc,
		sube: ~ckc,
		subq: ~ckb
	};

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// me trails mq by one 6m edge while the chain runs
	a_me_lags_mq: assert property (
		@(posedge clk_6m) !(reset || clear) |=> phase.me == $past(phase.mq)
	) else $error("me does not follow mq by one edge");

endmodule

`default_nettype wire

/* design/cus47_vblank_watchdog.sv */
`timescale 1ns/1ps
`default_nettype none

module cus47_vblank_watchdog #(
	parameter int watchdog_width = 4
) (
	input  logic                           clk_6m,
	input  logic                           reset,
	input  logic                           vblk,
	input  sys86_timing_pkg::ctrl_strobe_t strobe,
	output logic                           irq,
	output logic                           wdog_reset
);

	////////////////////////////////////////
	// vblank edge detect
	////////////////////////////////////////

	logic vblk_q;
	logic vblk_rise;

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			vblk_q <= 1'b0;
		end else begin
			vblk_q <= vblk;
		end
	end

	// one cycle pulse at the start of each blank
	assign vblk_rise = vblk & ~vblk_q;

	////////////////////////////////////////
	// interrupt flag
	////////////////////////////////////////

	// acknowledge beats a new blank in the same cycle
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			irq <= 1'b0;
		end else if (strobe.irq_ack) begin
			irq <= 1'b0;
		end else if (vblk_rise) begin
			irq <= 1'b1;
		end
	end

	////////////////////////////////////////
	// watchdog counter
	////////////////////////////////////////

	logic [watchdog_width-1:0] wdog_cnt;

	// counts blanks since the last kick
	// kick wins over a blank in the same cycle
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			wdog_cnt <= '0;
		end else if (strobe.wdog_kick) begin
			wdog_cnt <= '0;
		end else if (vblk_rise) begin
			wdog_cnt <= wdog_cnt + 1'b1;
		end
	end

	// top bit sets after 2**(width-1) unkicked blanks
	assign wdog_reset = wdog_cnt[watchdog_width-1];

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_ack_clears_irq: assert property (
		@(posedge clk_6m) disable iff (reset)
		strobe.irq_ack |=> !irq
	) else $error("irq still set after acknowledge");

	a_kick_clears_wdog: assert property (
		@(posedge clk_6m) disable iff (reset)
		strobe.wdog_kick |=> !wdog_reset
	) else $error("watchdog reset still set after kick");

endmodule

`default_nettype wire

/* design/sys86_bus_pkg.sv */
`default_nettype none

package sys86_bus_pkg;

	////////////////////////////////////////
	// sub cpu upper address, a15 down to a10
	////////////////////////////////////////

	// high three bits pick the 8 KB region
	// low three bits pick the 1 KB page inside it
	typedef struct packed {
		logic [2:0] region;
		logic [2:0] sub;
	} addr_split_t;

	// same six address bits seen two ways
	typedef union packed {
		logic [5:0]  page;
		addr_split_t split;
	} addr_page_u;

	////////////////////////////////////////
	// chip selects and latch strobes
	////////////////////////////////////////

	typedef struct packed {
		logic scr0;
		logic scr1;
		logic obj;
		logic snd;
		logic spgm;
		logic mpgm;
		logic bank;
		logic lth0;
		logic lth1;
		logic lth2;
		logic bufen;
	} cpu_select_t;

	// 8 KB regions
	// video ram 1 at 0000h
	localparam logic [2:0] region_scr0 = 3'd0;
	// video ram 2 at 2000h
	localparam logic [2:0] region_scr1 = 3'd1;
	// sprite ram at 4000h
	localparam logic [2:0] region_obj  = 3'd2;
	// sub program rom at 6000h, read only
	localparam logic [2:0] region_spgm = 3'd3;

	// 1 KB pages
	// sound chip shares its page with sprite ram
	localparam logic [5:0] page_snd     = 6'd16;
	localparam logic [5:0] page_wdog    = 6'd32;
	localparam logic [5:0] page_irq_ack = 6'd33;
	// tile bank select at 8c00h
	localparam logic [5:0] page_bank    = 6'd35;
	// scroll and priority latches
	localparam logic [5:0] page_lth0    = 6'd36;
	localparam logic [5:0] page_lth1    = 6'd37;
	// back colour, a000h
	localparam logic [5:0] page_lth2    = 6'd40;

endpackage

`default_nettype wire

/* design/sys86_timing_pkg.sv */
`default_nettype none

package sys86_timing_pkg;

	////////////////////////////////////////
	// bus phases
	////////////////////////////////////////

	// quadrature strobes for both cpus
	// me and sube are complements, so are mq and subq
	typedef struct packed {
		logic mq;
		logic me;
		logic sube;
		logic subq;
	} bus_phase_t;

	////////////////////////////////////////
	// control strobes
	////////////////////////////////////////

	// write strobes from the decoder into the vblank block
	typedef struct packed {
		logic irq_ack;
		logic wdog_kick;
	} ctrl_strobe_t;

endpackage

`default_nettype wire

/* testbench/tb_cus47.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cus47;

	localparam int wd_width = 3;
	localparam int timeout_cycles = 100;

	logic                         clk_6m;
	logic                         reset;
	logic                         clk_2h;
	logic                         vblk;
	logic                         we;
	sys86_bus_pkg::addr_page_u    a;
	sys86_timing_pkg::bus_phase_t phase;
	sys86_bus_pkg::cpu_select_t   sel;
	logic                         irq;
	logic                         wdog_reset;

	// values applied 1 ns after the next rising edge
	logic       next_reset;
	logic       next_clk_2h;
	logic       next_vblk;
	logic       next_we;
	logic [5:0] next_a;

	// reference model state
	logic                m_ckb;
	logic                m_ckc;
	logic                m_vblk_q;
	logic                m_irq;
	logic [wd_width-1:0] m_cnt;

	logic [31:0] rng_state;
	int          errors;
	int          test_err_start;
	int          passed;
	int          failed;

	cus47 #(
		.watchdog_width (wd_width)
	) dut_i (
		.clk_6m     (clk_6m),
		.reset      (reset),
		.clk_2h     (clk_2h),
		.vblk       (vblk),
		.we         (we),
		.a          (a),
		.phase      (phase),
		.sel        (sel),
		.irq        (irq),
		.wdog_reset (wdog_reset)
	);

	initial begin
		clk_6m = 1'b0;
		forever #5 clk_6m = ~clk_6m;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// selects in struct order, scr0 first, bufen last
	function automatic logic [10:0] expected_sel(input logic w, input logic [5:0] pg);
		logic s0, s1, ob, sn, l0, l1;
		s0 = (pg[5:3] == sys86_bus_pkg::region_scr0);
		s1 = (pg[5:3] == sys86_bus_pkg::region_scr1);
		ob = (pg[5:3] == sys86_bus_pkg::region_obj);
		sn = (pg == sys86_bus_pkg::page_snd);
		l0 = w && (pg == sys86_bus_pkg::page_lth0);
		l1 = w && (pg == sys86_bus_pkg::page_lth1);
		return {s0, s1, ob, sn,
			!w && (pg[5:3] == sys86_bus_pkg::region_spgm),
			!w && pg[5],
			w && (pg == sys86_bus_pkg::page_bank),
			l0, l1,
			w && (pg == sys86_bus_pkg::page_lth2),
			s0 | s1 | ob | sn | l0 | l1};
	endfunction

	task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic report_test(input string name);
		if (errors == test_err_start) begin
			passed++;
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: %0d errors", name, errors - test_err_start);
		end
		test_err_start = errors;
	endtask

	// one clock: model update at the edge, drive, then check all outputs
	task automatic run_cycle;
		logic rise, ack, kick, clr;
		@(posedge clk_6m);
		rise = vblk & ~m_vblk_q;
		ack  = we && (a.page == sys86_bus_pkg::page_irq_ack);
		kick = we && (a.page == sys86_bus_pkg::page_wdog);
		clr  = m_cnt[wd_width-1];
		if (reset) begin
			m_ckb = 1'b0;
			m_ckc = 1'b0;
			m_vblk_q = 1'b0;
			m_irq = 1'b0;
			m_cnt = '0;
		end else begin
			m_ckc = clr ? 1'b0 : m_ckb;
			m_ckb = clr ? 1'b0 : clk_2h;
			m_vblk_q = vblk;
			if (ack)
				m_irq = 1'b0;
			else if (rise)
				m_irq = 1'b1;
			if (kick)
				m_cnt = '0;
			else if (rise)
				m_cnt = m_cnt + 1'b1;
		end
		#1;
		reset  = next_reset;
		clk_2h = next_clk_2h;
		vblk   = next_vblk;
		we     = next_we;
		a.page = next_a;
		#1;
		compare_values(phase, {m_ckb, m_ckc, ~m_ckc, ~m_ckb}, "phase");
		compare_values(irq, m_irq, "irq");
		compare_values(wdog_reset, m_cnt[wd_width-1], "wdog_reset");
		compare_values(sel, expected_sel(we, a.page), "sel");
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic verify_reset;
		compare_values(phase, 4'b0011, "phase after reset");
		compare_values(irq, 1'b0, "irq after reset");
		compare_values(wdog_reset, 1'b0, "wdog_reset after reset");
		report_test("reset values");
	endtask

	// bus idle, 2h level random
	task automatic follow_clk_2h;
		logic [31:0] r;
		for (int i = 0; i < 200; i++) begin
			next_random(r);
			next_clk_2h = r[0];
			next_we = 1'b0;
			next_vblk = 1'b0;
			next_a = r[13:8];
			run_cycle();
		end
		report_test("phase following");
	endtask

	task automatic sweep_decoder;
		logic [31:0] r;
		for (int i = 0; i < 300; i++) begin
			next_random(r);
			next_clk_2h = r[0];
			next_we = r[1];
			next_a = r[9:4];
			run_cycle();
		end
		next_we = 1'b0;
		report_test("address decoding");
	endtask

	task automatic pulse_interrupts;
		logic [31:0] r;
		int n;
		next_vblk = 1'b0;
		run_cycle();
		run_cycle();
		next_vblk = 1'b1;
		run_cycle();
		n = 0;
		while (!irq && n < timeout_cycles) begin
			run_cycle();
			n++;
		end
		if (!irq)
			abort_on_timeout("irq after a vertical blank");
		// new blank and acknowledge in the same cycle
		next_vblk = 1'b0;
		run_cycle();
		next_vblk = 1'b1;
		next_we = 1'b1;
		next_a = sys86_bus_pkg::page_irq_ack;
		run_cycle();
		next_we = 1'b0;
		next_vblk = 1'b0;
		run_cycle();
		compare_values(irq, 1'b0, "irq when ack meets a new blank");
		// random blanks, acks and kicks
		for (int i = 0; i < 200; i++) begin
			next_random(r);
			next_vblk = r[3] & r[4];
			next_we = (r[7:5] == 3'd0) || (r[7:5] == 3'd1);
			next_a = r[5] ? sys86_bus_pkg::page_wdog : sys86_bus_pkg::page_irq_ack;
			if (!next_we)
				next_a = r[21:16];
			next_clk_2h = r[9];
			run_cycle();
		end
		next_we = 1'b0;
		next_vblk = 1'b0;
		report_test("interrupt");
	endtask

	task automatic starve_watchdog;
		int n;
		int rises;
		next_we = 1'b1;
		next_a = sys86_bus_pkg::page_wdog;
		run_cycle();
		next_we = 1'b0;
		next_clk_2h = 1'b1;
		run_cycle();
		n = 0;
		rises = 0;
		while (!wdog_reset && n < timeout_cycles) begin
			next_vblk = ~next_vblk;
			if (next_vblk)
				rises++;
			run_cycle();
			n++;
		end
		if (!wdog_reset)
			abort_on_timeout("watchdog reset without kicks");
		compare_values(rises, 2 ** (wd_width - 1), "blanks before watchdog reset");
		next_vblk = 1'b0;
		run_cycle();
		compare_values(phase.mq, 1'b0, "mq during watchdog reset");
		compare_values(phase.me, 1'b0, "me during watchdog reset");
		next_we = 1'b1;
		run_cycle();
		next_we = 1'b0;
		n = 0;
		while (wdog_reset && n < timeout_cycles) begin
			run_cycle();
			n++;
		end
		if (wdog_reset)
			abort_on_timeout("watchdog reset to clear after a kick");
		run_cycle();
		run_cycle();
		report_test("watchdog reset");
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		clk_2h = 1'b0;
		vblk = 1'b0;
		we = 1'b0;
		a.page = 6'd0;
		next_reset = 1'b1;
		next_clk_2h = 1'b0;
		next_vblk = 1'b0;
		next_we = 1'b0;
		next_a = 6'd0;
		m_ckb = 1'b0;
		m_ckc = 1'b0;
		m_vblk_q = 1'b0;
		m_irq = 1'b0;
		m_cnt = '0;
		rng_state = 32'h2122_fb65;
		errors = 0;
		test_err_start = 0;
		passed = 0;
		failed = 0;
		// reset seen by five rising edges
		for (int i = 0; i < 5; i++) begin
			if (i == 4)
				next_reset = 1'b0;
			run_cycle();
		end
		verify_reset();
		follow_clk_2h();
		sweep_decoder();
		pulse_interrupts();
		starve_watchdog();
		$display("tests passed: %0d, tests failed: %0d", passed, failed);
		if (failed == 0 && errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
